// ==== design/dmmu_params.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TLB geometry and SPR map of the data MMU
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DMMU_PARAMS_SVH
`define DMMU_PARAMS_SVH

// 64 sets, one way
`define DMMU_SET_WIDTH 6

// 8 KB pages
`define DMMU_PAGE_BITS 13

// Control register and TLB register groups
`define DMMU_SPR_CR_ADDR    16'h0800
`define DMMU_SPR_MATCH_BASE 16'h0A00
`define DMMU_SPR_TRANS_BASE 16'h0A80

`endif

// ==== design/dmmu_tlb_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TLB entry and page-table word layouts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package dmmu_tlb_pkg;

   typedef struct packed {
      logic [18:0] vpn;
      logic [11:0] rsvd;
      logic        valid;
   } tlb_match_t;

   typedef struct packed {
      logic [18:0] ppn;
      logic [2:0]  rsvd;
      logic        swe;
      logic        sre;
      logic        uwe;
      logic        ure;
      logic        dirty;
      logic        accessed;
      logic        wom;
      logic        wbc;
      logic        ci;
      logic        cc;
   } tlb_trans_t;

   // Second-level entry, low six bits match tlb_trans_t
   typedef struct packed {
      logic [18:0] ppn;
      logic [1:0]  rsvd;
      logic        present;
      logic        last;
      logic        x;
      logic        w;
      logic        u;
      logic        dirty;
      logic        accessed;
      logic        wom;
      logic        wbc;
      logic        ci;
      logic        cc;
   } pte_t;

   typedef struct packed {
      logic [18:0] ptr;
      logic [12:0] unused;
   } pgd_t;

   // Directory pointer in step one, PTE in step two
   typedef union packed {
      pte_t pte;
      pgd_t pgd;
   } reload_word_u;

endpackage

// ==== design/dmmu_spr_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPR target decode for the data MMU
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package dmmu_spr_pkg;

   typedef enum logic [1:0] {
      SPR_NONE,
      SPR_CR,
      SPR_MATCH,
      SPR_TRANS
   } spr_sel_e;

endpackage

// ==== design/tlb_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TLB storage, one registered read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "dmmu_params.svh"

module tlb_ram (
   input  logic                       clk,
   input  logic [`DMMU_SET_WIDTH-1:0] raddr_i,
   output logic [31:0]                rdata_o,
   input  logic                       we_i,
   input  logic [`DMMU_SET_WIDTH-1:0] waddr_i,
   input  logic [31:0]                wdata_i
);

   logic [31:0] mem [2**`DMMU_SET_WIDTH];

   // Old data comes out on a same-address collision
   always_ff @(posedge clk) begin
      rdata_o <= mem[raddr_i];
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   a_waddr_known: assert property (@(posedge clk) we_i |-> !$isunknown(waddr_i));

endmodule

// ==== design/dmmu_tlb_access.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPR decode, DMMUCR and TLB port arbitration
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "dmmu_params.svh"

module dmmu_tlb_access (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        spr_stb_i,
   input  logic                        spr_we_i,
   input  logic [15:0]                 spr_addr_i,
   input  logic [31:0]                 spr_wdata_i,
   output logic [31:0]                 spr_rdata_o,
   output logic                        spr_ack_o,
   output logic [21:0]                 cr_base_o,
   input  logic [`DMMU_SET_WIDTH-1:0]  lkp_index_i,
   input  logic                        rl_we_i,
   input  logic [`DMMU_SET_WIDTH-1:0]  rl_index_i,
   input  dmmu_tlb_pkg::tlb_match_t    rl_match_i,
   input  dmmu_tlb_pkg::tlb_trans_t    rl_trans_i,
   input  logic [31:0]                 match_rdata_i,
   input  logic [31:0]                 trans_rdata_i,
   output logic [`DMMU_SET_WIDTH-1:0]  ram_raddr_o,
   output logic                        match_we_o,
   output logic                        trans_we_o,
   output logic [`DMMU_SET_WIDTH-1:0]  ram_waddr_o,
   output logic [31:0]                 match_wdata_o,
   output logic [31:0]                 trans_wdata_o,
   output logic                        spr_busy_o
);

   localparam logic [15:0] MATCH_BASE = `DMMU_SPR_MATCH_BASE;
   localparam logic [15:0] TRANS_BASE = `DMMU_SPR_TRANS_BASE;

   dmmu_spr_pkg::spr_sel_e sel, sel_q;
   logic        ack_q;
   logic        spr_wr;
   logic [31:0] dmmucr;

   always_comb begin
      sel = dmmu_spr_pkg::SPR_NONE;
      if (spr_stb_i) begin
         if (spr_addr_i == `DMMU_SPR_CR_ADDR)
            sel = dmmu_spr_pkg::SPR_CR;
         else if (spr_addr_i[15:`DMMU_SET_WIDTH] == MATCH_BASE[15:`DMMU_SET_WIDTH])
            sel = dmmu_spr_pkg::SPR_MATCH;
         else if (spr_addr_i[15:`DMMU_SET_WIDTH] == TRANS_BASE[15:`DMMU_SET_WIDTH])
            sel = dmmu_spr_pkg::SPR_TRANS;
      end
   end

   // A reload write holds off the SPR access by one cycle
   assign spr_wr = spr_stb_i && spr_we_i && !ack_q && !rl_we_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         ack_q  <= 1'b0;
         sel_q  <= dmmu_spr_pkg::SPR_NONE;
         dmmucr <= '0;
      end else begin
         ack_q <= spr_stb_i && !ack_q && !rl_we_i;
         sel_q <= sel;
         if (spr_wr && sel == dmmu_spr_pkg::SPR_CR)
            dmmucr <= spr_wdata_i;
      end
   end

   assign spr_ack_o  = ack_q;
   assign spr_busy_o = spr_stb_i;
   assign cr_base_o  = dmmucr[31:10];

   always_comb begin
      case (sel_q)
         dmmu_spr_pkg::SPR_CR:    spr_rdata_o = dmmucr;
         dmmu_spr_pkg::SPR_MATCH: spr_rdata_o = match_rdata_i;
         dmmu_spr_pkg::SPR_TRANS: spr_rdata_o = trans_rdata_i;
         default:                 spr_rdata_o = '0;
      endcase
   end

   // SPR set number while the bus owns the RAMs
   assign ram_raddr_o = (sel == dmmu_spr_pkg::SPR_MATCH || sel == dmmu_spr_pkg::SPR_TRANS) ?
                        spr_addr_i[`DMMU_SET_WIDTH-1:0] : lkp_index_i;

   assign match_we_o    = rl_we_i || (spr_wr && sel == dmmu_spr_pkg::SPR_MATCH);
   assign trans_we_o    = rl_we_i || (spr_wr && sel == dmmu_spr_pkg::SPR_TRANS);
   assign ram_waddr_o   = rl_we_i ? rl_index_i : spr_addr_i[`DMMU_SET_WIDTH-1:0];
   assign match_wdata_o = rl_we_i ? rl_match_i : spr_wdata_i;
   assign trans_wdata_o = rl_we_i ? rl_trans_i : spr_wdata_i;

   a_ack_single: assert property (@(posedge clk) disable iff (rst)
      spr_ack_o |=> !spr_ack_o);

endmodule

// ==== design/dmmu_lookup.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Request stage, TLB compare and response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "dmmu_params.svh"

module dmmu_lookup (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       enable_i,
   input  logic                       req_valid_i,
   output logic                       req_ready_o,
   input  logic [31:0]                req_addr_i,
   input  logic                       req_store_i,
   input  logic                       req_super_i,
   input  logic                       spr_busy_i,
   output logic [`DMMU_SET_WIDTH-1:0] lkp_index_o,
   input  dmmu_tlb_pkg::tlb_match_t   match_rdata_i,
   input  dmmu_tlb_pkg::tlb_trans_t   trans_rdata_i,
   input  logic [21:0]                cr_base_i,
   output logic                       resp_valid_o,
   output logic [31:0]                resp_paddr_o,
   output logic                       resp_ci_o,
   output logic                       resp_miss_o,
   output logic                       resp_fault_o,
   output logic                       miss_start_o,
   output logic [31:0]                miss_addr_o,
   input  logic                       rl_busy_i,
   input  logic                       rl_done_i,
   input  logic                       rl_fault_i
);

   logic        s_valid;
   logic [31:0] s_addr;
   logic        s_store;
   logic        s_super;
   logic        wait_q;
   logic        rep_q;
   logic        flt_q;
   logic        abt_q;
   logic        accept;
   logic        replay_go;
   logic        hit;
   logic        base_nz;
   logic        perm_ok;
   logic        walk_abort;

   assign base_nz    = cr_base_i != '0;
   assign walk_abort = !enable_i || !base_nz;

   assign hit = match_rdata_i.valid &&
                match_rdata_i.vpn == s_addr[31:`DMMU_PAGE_BITS];

   always_comb begin
      if (s_super)
         perm_ok = s_store ? trans_rdata_i.swe : trans_rdata_i.sre;
      else
         perm_ok = s_store ? trans_rdata_i.uwe : trans_rdata_i.ure;
   end

   assign miss_start_o = s_valid && enable_i && !hit && base_nz;
   assign miss_addr_o  = s_addr;

   // Stop taking requests while a miss is outstanding
   assign req_ready_o = !wait_q && !rep_q && !rl_busy_i && !spr_busy_i && !miss_start_o;
   assign accept      = req_valid_i && req_ready_o;
   assign replay_go   = rep_q && !spr_busy_i;

   assign lkp_index_o = rep_q ? s_addr[`DMMU_PAGE_BITS +: `DMMU_SET_WIDTH] :
                        req_addr_i[`DMMU_PAGE_BITS +: `DMMU_SET_WIDTH];

   assign resp_valid_o = (s_valid && !miss_start_o) || flt_q || abt_q;
   assign resp_paddr_o = (s_valid && enable_i && hit) ?
                         {trans_rdata_i.ppn, s_addr[`DMMU_PAGE_BITS-1:0]} : s_addr;
   assign resp_ci_o    = s_valid && enable_i && hit && trans_rdata_i.ci;
   assign resp_miss_o  = abt_q || (s_valid && enable_i && !hit && !base_nz);
   assign resp_fault_o = flt_q || (s_valid && enable_i && hit && !perm_ok);

   // Held through a walk so the replay can use it
   always_ff @(posedge clk) begin
      if (accept) begin
         s_addr  <= req_addr_i;
         s_store <= req_store_i;
         s_super <= req_super_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         s_valid <= 1'b0;
         wait_q  <= 1'b0;
         rep_q   <= 1'b0;
         flt_q   <= 1'b0;
         abt_q   <= 1'b0;
      end else begin
         s_valid <= accept || replay_go;
         flt_q   <= wait_q && rl_fault_i;
         abt_q   <= wait_q && !rl_fault_i && !rl_done_i && walk_abort;
         if (miss_start_o)
            wait_q <= 1'b1;
         else if (rl_fault_i || rl_done_i || walk_abort)
            wait_q <= 1'b0;
         if (wait_q && rl_done_i)
            rep_q <= 1'b1;
         else if (replay_go)
            rep_q <= 1'b0;
      end
   end

   a_resp_or_walk: assert property (@(posedge clk) disable iff (rst)
      !(resp_valid_o && miss_start_o));

endmodule

// ==== design/dmmu_reload.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-level page-table walker, refills TLB
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "dmmu_params.svh"

module dmmu_reload (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       enable_i,
   input  logic [21:0]                cr_base_i,
   input  logic                       miss_start_i,
   input  logic [31:0]                miss_addr_i,
   output logic                       mem_valid_o,
   input  logic                       mem_ready_i,
   output logic [31:0]                mem_addr_o,
   input  logic [31:0]                mem_rdata_i,
   output logic                       rl_busy_o,
   output logic                       rl_done_o,
   output logic                       rl_fault_o,
   output logic                       rl_we_o,
   output logic [`DMMU_SET_WIDTH-1:0] rl_index_o,
   output dmmu_tlb_pkg::tlb_match_t   rl_match_o,
   output dmmu_tlb_pkg::tlb_trans_t   rl_trans_o
);

   localparam logic [1:0] ST_IDLE   = 2'd0;
   localparam logic [1:0] ST_DIR    = 2'd1;
   localparam logic [1:0] ST_PTE    = 2'd2;
   localparam logic [1:0] ST_SETTLE = 2'd3;

   logic [1:0]                 state;
   logic [31:0]                vaddr;
   logic                       abort;
   dmmu_tlb_pkg::reload_word_u word;

   assign word       = mem_rdata_i;
   assign abort      = !enable_i || cr_base_i == '0;
   assign rl_busy_o  = state != ST_IDLE;
   assign rl_index_o = vaddr[`DMMU_PAGE_BITS +: `DMMU_SET_WIDTH];

   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= ST_IDLE;
         mem_valid_o <= 1'b0;
         rl_we_o     <= 1'b0;
         rl_done_o   <= 1'b0;
         rl_fault_o  <= 1'b0;
      end else begin
         rl_we_o    <= 1'b0;
         rl_done_o  <= 1'b0;
         rl_fault_o <= 1'b0;
         case (state)
            ST_IDLE: if (miss_start_i) begin
               mem_valid_o <= 1'b1;
               state       <= ST_DIR;
            end
            ST_DIR: if (mem_ready_i) begin
               if (word.pgd.ptr == '0) begin
                  mem_valid_o <= 1'b0;
                  rl_fault_o  <= 1'b1;
                  state       <= ST_IDLE;
               end else begin
                  state <= ST_PTE;
               end
            end
            ST_PTE: if (mem_ready_i) begin
               mem_valid_o <= 1'b0;
               if (!word.pte.present) begin
                  rl_fault_o <= 1'b1;
                  state      <= ST_IDLE;
               end else begin
                  rl_we_o <= 1'b1;
                  state   <= ST_SETTLE;
               end
            end
            // RAMs take the entry this cycle
            ST_SETTLE: begin
               rl_done_o <= 1'b1;
               state     <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
         // Translation off or table gone mid-walk
         if (state != ST_IDLE && abort) begin
            state       <= ST_IDLE;
            mem_valid_o <= 1'b0;
            rl_done_o   <= 1'b0;
            rl_fault_o  <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == ST_IDLE && miss_start_i) begin
         vaddr      <= miss_addr_i;
         mem_addr_o <= {cr_base_i, miss_addr_i[31:24], 2'b00};
      end else if (state == ST_DIR && mem_ready_i) begin
         mem_addr_o <= {word.pgd.ptr, vaddr[23:`DMMU_PAGE_BITS], 2'b00};
      end
      if (state == ST_PTE && mem_ready_i) begin
         rl_match_o <= '{vpn: vaddr[31:`DMMU_PAGE_BITS], rsvd: '0, valid: 1'b1};
         // Supervisor may always read
         rl_trans_o <= '{ppn:      word.pte.ppn,
                         rsvd:     '0,
                         swe:      word.pte.w,
                         sre:      1'b1,
                         uwe:      word.pte.w & word.pte.u,
                         ure:      word.pte.u,
                         dirty:    word.pte.dirty,
                         accessed: word.pte.accessed,
                         wom:      word.pte.wom,
                         wbc:      word.pte.wbc,
                         ci:       word.pte.ci,
                         cc:       word.pte.cc};
      end
   end

   a_addr_stable: assert property (@(posedge clk) disable iff (rst)
      mem_valid_o && !mem_ready_i |=> $stable(mem_addr_o));

endmodule

// ==== design/dmmu_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data MMU top, connects access, lookup, walker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "dmmu_params.svh"

module dmmu_top (
   input  logic        clk,
   input  logic        rst,
   input  logic        enable_i,
   input  logic        req_valid_i,
   output logic        req_ready_o,
   input  logic [31:0] req_addr_i,
   input  logic        req_store_i,
   input  logic        req_super_i,
   output logic        resp_valid_o,
   output logic [31:0] resp_paddr_o,
   output logic        resp_ci_o,
   output logic        resp_miss_o,
   output logic        resp_fault_o,
   input  logic        spr_stb_i,
   input  logic        spr_we_i,
   input  logic [15:0] spr_addr_i,
   input  logic [31:0] spr_wdata_i,
   output logic [31:0] spr_rdata_o,
   output logic        spr_ack_o,
   output logic        mem_valid_o,
   input  logic        mem_ready_i,
   output logic [31:0] mem_addr_o,
   input  logic [31:0] mem_rdata_i
);

   logic [`DMMU_SET_WIDTH-1:0] lkp_index;
   logic [`DMMU_SET_WIDTH-1:0] ram_raddr;
   logic [`DMMU_SET_WIDTH-1:0] ram_waddr;
   logic [`DMMU_SET_WIDTH-1:0] rl_index;
   logic [31:0]                match_rdata;
   logic [31:0]                trans_rdata;
   logic [31:0]                match_wdata;
   logic [31:0]                trans_wdata;
   logic                       match_we;
   logic                       trans_we;
   logic [21:0]                cr_base;
   logic                       spr_busy;
   logic                       miss_start;
   logic [31:0]                miss_addr;
   logic                       rl_busy;
   logic                       rl_done;
   logic                       rl_fault;
   logic                       rl_we;
   dmmu_tlb_pkg::tlb_match_t   rl_match;
   dmmu_tlb_pkg::tlb_trans_t   rl_trans;

   dmmu_tlb_access u_access (
      .clk, .rst,
      .spr_stb_i, .spr_we_i, .spr_addr_i, .spr_wdata_i, .spr_rdata_o, .spr_ack_o,
      .cr_base_o(cr_base), .lkp_index_i(lkp_index),
      .rl_we_i(rl_we), .rl_index_i(rl_index), .rl_match_i(rl_match), .rl_trans_i(rl_trans),
      .match_rdata_i(match_rdata), .trans_rdata_i(trans_rdata), .ram_raddr_o(ram_raddr),
      .match_we_o(match_we), .trans_we_o(trans_we), .ram_waddr_o(ram_waddr),
      .match_wdata_o(match_wdata), .trans_wdata_o(trans_wdata), .spr_busy_o(spr_busy)
   );

   tlb_ram match_ram (
      .clk, .raddr_i(ram_raddr), .rdata_o(match_rdata),
      .we_i(match_we), .waddr_i(ram_waddr), .wdata_i(match_wdata)
   );

   tlb_ram trans_ram (
      .clk, .raddr_i(ram_raddr), .rdata_o(trans_rdata),
      .we_i(trans_we), .waddr_i(ram_waddr), .wdata_i(trans_wdata)
   );

   dmmu_lookup u_lookup (
      .clk, .rst, .enable_i,
      .req_valid_i, .req_ready_o, .req_addr_i, .req_store_i, .req_super_i,
      .spr_busy_i(spr_busy), .lkp_index_o(lkp_index),
      .match_rdata_i(match_rdata), .trans_rdata_i(trans_rdata), .cr_base_i(cr_base),
      .resp_valid_o, .resp_paddr_o, .resp_ci_o, .resp_miss_o, .resp_fault_o,
      .miss_start_o(miss_start), .miss_addr_o(miss_addr),
      .rl_busy_i(rl_busy), .rl_done_i(rl_done), .rl_fault_i(rl_fault)
   );

   dmmu_reload u_reload (
      .clk, .rst, .enable_i, .cr_base_i(cr_base),
      .miss_start_i(miss_start), .miss_addr_i(miss_addr),
      .mem_valid_o, .mem_ready_i, .mem_addr_o, .mem_rdata_i,
      .rl_busy_o(rl_busy), .rl_done_o(rl_done), .rl_fault_o(rl_fault),
      .rl_we_o(rl_we), .rl_index_o(rl_index), .rl_match_o(rl_match), .rl_trans_o(rl_trans)
   );

endmodule

// ==== bench/page_table_mem.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reload memory model, answers two cycles after valid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module page_table_mem (
   input  logic        clk,
   input  logic        rst,
   input  logic        valid_i,
   input  logic [31:0] addr_i,
   output logic        ready_o,
   output logic [31:0] rdata_o
);

   logic [31:0] words [logic [31:0]];
   logic        cnt;

   // Filled by the testbench before a walk
   task load_word(input logic [31:0] a, input logic [31:0] v);
      words[a] = v;
   endtask

   always_ff @(posedge clk) begin
      if (rst) begin
         cnt     <= 1'b0;
         ready_o <= 1'b0;
      end else begin
         ready_o <= valid_i && !ready_o && cnt;
         cnt     <= valid_i && !ready_o && !cnt;
      end
   end

   // Unwritten words read as zero
   always_comb begin
      rdata_o = words.exists(addr_i) ? words[addr_i] : 32'h0;
   end

endmodule

// ==== bench/dmmu_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data MMU testbench, reference queue checks against the DUT
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "dmmu_params.svh"

module dmmu_tb;

   typedef struct packed {
      logic [31:0] paddr;
      logic        ci;
      logic        miss;
      logic        fault;
   } exp_t;

   logic        clk, rst, enable;
   logic        req_valid, req_ready, req_store, req_super;
   logic [31:0] req_addr;
   logic        resp_valid, resp_ci, resp_miss, resp_fault;
   logic [31:0] resp_paddr;
   logic        spr_stb, spr_we, spr_ack;
   logic [15:0] spr_addr;
   logic [31:0] spr_wdata, spr_rdata;
   logic        mem_valid, mem_ready;
   logic [31:0] mem_addr, mem_rdata;

   exp_t        exp_resp[$];
   logic [31:0] exp_mem[$];
   exp_t        e;
   logic [31:0] ref_match[64];
   logic [31:0] ref_trans[64];
   logic [31:0] ref_cr;
   logic [31:0] pt_words[logic [31:0]];
   logic [31:0] seed = 32'hac3f;
   logic [18:0] ptrs[6];
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;

   dmmu_top uut (
      .clk, .rst, .enable_i(enable),
      .req_valid_i(req_valid), .req_ready_o(req_ready), .req_addr_i(req_addr),
      .req_store_i(req_store), .req_super_i(req_super),
      .resp_valid_o(resp_valid), .resp_paddr_o(resp_paddr), .resp_ci_o(resp_ci),
      .resp_miss_o(resp_miss), .resp_fault_o(resp_fault),
      .spr_stb_i(spr_stb), .spr_we_i(spr_we), .spr_addr_i(spr_addr),
      .spr_wdata_i(spr_wdata), .spr_rdata_o(spr_rdata), .spr_ack_o(spr_ack),
      .mem_valid_o(mem_valid), .mem_ready_i(mem_ready), .mem_addr_o(mem_addr),
      .mem_rdata_i(mem_rdata)
   );

   page_table_mem ptm (
      .clk, .rst, .valid_i(mem_valid), .addr_i(mem_addr),
      .ready_o(mem_ready), .rdata_o(mem_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   task automatic report_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] got_v);
      errors++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp_v, got_v);
   endtask

   task automatic report_text(input string msg);
      errors++;
      $display("FAIL t=%0t %s", $time, msg);
   endtask

   task automatic pt_write(input logic [31:0] a, input logic [31:0] v);
      pt_words[a] = v;
      ptm.load_word(a, v);
   endtask

   function automatic logic [31:0] pt_read(input logic [31:0] a);
      return pt_words.exists(a) ? pt_words[a] : 32'h0;
   endfunction

   // Reference model of one lookup, including any walk it causes
   task automatic predict(input logic [31:0] a, input logic st, input logic su);
      exp_t        r;
      logic [5:0]  idx;
      logic [31:0] m, t, dw, pw, da, pa;
      logic        use_entry;
      idx = a[18:13];
      r = '0;
      r.paddr = a;
      m = ref_match[idx];
      t = ref_trans[idx];
      use_entry = 1'b0;
      if (enable) begin
         if (m[0] && m[31:13] == a[31:13]) begin
            use_entry = 1'b1;
         end else if (ref_cr[31:10] == 22'h0) begin
            r.miss = 1'b1;
         end else begin
            da = {ref_cr[31:10], a[31:24], 2'b00};
            exp_mem.push_back(da);
            dw = pt_read(da);
            if (dw[31:13] == 19'h0) begin
               r.fault = 1'b1;
            end else begin
               pa = {dw[31:13], a[23:13], 2'b00};
               exp_mem.push_back(pa);
               pw = pt_read(pa);
               if (!pw[10]) begin
                  r.fault = 1'b1;
               end else begin
                  t = {pw[31:13], 3'b000, pw[7], 1'b1, pw[7] & pw[6], pw[6], pw[5:0]};
                  ref_match[idx] = {a[31:13], 12'h0, 1'b1};
                  ref_trans[idx] = t;
                  use_entry = 1'b1;
               end
            end
         end
      end
      if (use_entry) begin
         r.paddr = {t[31:13], a[12:0]};
         r.ci    = t[1];
         r.fault = su ? !(st ? t[9] : t[8]) : !(st ? t[7] : t[6]);
      end
      exp_resp.push_back(r);
   endtask

   task automatic spr_xfer(input logic we, input logic [15:0] a, input logic [31:0] wd,
                           output logic [31:0] rd);
      int n;
      @(posedge clk);
      spr_stb   <= 1'b1;
      spr_we    <= we;
      spr_addr  <= a;
      spr_wdata <= wd;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!spr_ack && n < 20);
      rd = spr_rdata;
      checks++;
      // Strobe cycle, then the ack cycle
      if (n != 2)
         report_text($sformatf("SPR ack took %0d cycles", n));
      @(posedge clk);
      spr_stb <= 1'b0;
      spr_we  <= 1'b0;
   endtask

   // Write then read back, updating the reference copy
   task automatic spr_write_check(input logic [15:0] a, input logic [31:0] v);
      logic [31:0] rd;
      spr_xfer(1'b1, a, v, rd);
      spr_xfer(1'b0, a, 32'h0, rd);
      checks++;
      assert (rd == v) else report_value("spr_rdata_o", v, rd);
      if (a == `DMMU_SPR_CR_ADDR)
         ref_cr = v;
      else if (a[15:6] == 10'(`DMMU_SPR_MATCH_BASE >> 6))
         ref_match[a[5:0]] = v;
      else
         ref_trans[a[5:0]] = v;
   endtask

   task automatic issue(input logic [31:0] a, input logic st, input logic su);
      @(posedge clk);
      req_valid <= 1'b1;
      req_addr  <= a;
      req_store <= st;
      req_super <= su;
      predict(a, st, su);
      do @(negedge clk); while (!req_ready);
   endtask

   task automatic drain();
      int n;
      @(posedge clk);
      req_valid <= 1'b0;
      n = 0;
      while ((exp_resp.size() != 0 || exp_mem.size() != 0) && n < 200) begin
         @(posedge clk);
         n++;
      end
      if (n >= 200)
         report_text("expected responses or memory requests never arrived");
      repeat (2) @(posedge clk);
   endtask

   always @(negedge clk) begin
      if (!rst && resp_valid) begin
         if (exp_resp.size() == 0) begin
            report_text("response with no request outstanding");
         end else begin
            e = exp_resp.pop_front();
            checks++;
            assert (resp_paddr == e.paddr)
               else report_value("resp_paddr_o", e.paddr, resp_paddr);
            assert (resp_ci == e.ci) else report_value("resp_ci_o", 32'(e.ci), 32'(resp_ci));
            assert (resp_miss == e.miss)
               else report_value("resp_miss_o", 32'(e.miss), 32'(resp_miss));
            assert (resp_fault == e.fault)
               else report_value("resp_fault_o", 32'(e.fault), 32'(resp_fault));
         end
      end
      if (!rst && mem_valid && mem_ready) begin
         if (exp_mem.size() == 0) begin
            report_text($sformatf("unexpected memory request at %h", mem_addr));
         end else begin
            checks++;
            assert (mem_addr == exp_mem[0])
               else report_value("mem_addr_o", exp_mem[0], mem_addr);
            void'(exp_mem.pop_front());
         end
      end
   end

   a_ack_next: assert property (@(posedge clk) disable iff (rst) $rose(spr_stb) |=> spr_ack)
      else report_text("spr_ack_o missing one cycle after strobe");

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= 4000) begin
         $display("FAIL t=%0t run exceeded 4000 cycles", $time);
         $display("=== FAIL ===");
         $finish;
      end
   end

   initial begin
      logic [31:0] va, r, r1;
      rst = 1'b1;
      enable = 1'b1;
      req_valid = 1'b0;
      req_addr = '0;
      req_store = 1'b0;
      req_super = 1'b0;
      spr_stb = 1'b0;
      spr_we = 1'b0;
      spr_addr = '0;
      spr_wdata = '0;
      ref_cr = '0;
      for (int i = 0; i < 64; i++) begin
         ref_match[i] = '0;
         ref_trans[i] = '0;
      end
      repeat (3) @(posedge clk);
      rst <= 1'b0;

      // Idle handshake state straight out of reset
      @(negedge clk);
      checks++;
      assert (req_ready && !resp_valid && !spr_ack && !mem_valid)
         else report_text("request, response, SPR or memory handshake not idle after reset");

      // SPR readback and TLB preload, set s carries permission nibble s
      spr_write_check(`DMMU_SPR_CR_ADDR, 32'h1234_5400);
      spr_write_check(`DMMU_SPR_CR_ADDR, 32'h0);
      for (int s = 0; s < 16; s++) begin
         r = lcg_next();
         r1 = lcg_next();
         spr_write_check(`DMMU_SPR_MATCH_BASE + 16'(s), {r[31:19], 6'(s), 12'h0, 1'b1});
         spr_write_check(`DMMU_SPR_TRANS_BASE + 16'(s), {r1[31:13], 3'b0, 4'(s), r1[5:0]});
      end
      spr_write_check(`DMMU_SPR_MATCH_BASE + 16'd20, {13'h55, 6'd20, 13'h0});

      // Hits over all permission and access combinations
      for (int s = 0; s < 16; s++) begin
         for (int acc = 0; acc < 4; acc++) begin
            r = lcg_next();
            issue({ref_match[s][31:13], r[12:0]}, acc[0], acc[1]);
         end
      end
      drain();

      // Misses with a zero page-table base
      for (int s = 0; s < 16; s++) begin
         r = lcg_next();
         issue({~ref_match[s][31], ref_match[s][30:13], r[12:0]}, 1'b0, 1'b1);
      end
      issue({13'h55, 6'd20, 13'h123}, 1'b0, 1'b1);
      drain();

      // Page table for the walker
      for (int i = 0; i < 6; i++) begin
         r = lcg_next();
         ptrs[i] = {r[18:1], 1'b1};
         pt_write({22'h10, 8'(i + 1), 2'b00}, {ptrs[i], 13'h0});
      end
      spr_write_check(`DMMU_SPR_CR_ADDR, {22'h10, 10'h0});
      for (int i = 0; i < 6; i++) begin
         r = lcg_next();
         r1 = lcg_next();
         va = {8'(i + 1), 1'b0, r[22:0]};
         pt_write({ptrs[i], va[23:13], 2'b00}, {r1[31:13], 2'b00, 1'b1, 2'b00, r1[7:0]});
         issue(va, r1[8], r1[9]);
         drain();
         issue(va, 1'b0, 1'b1);
         drain();
      end

      // Walk faults, empty directory slot and absent PTE
      pt_write({ptrs[0], 11'h7ff, 2'b00}, {19'h1, 13'h0});
      issue(32'hf000_4000, 1'b0, 1'b1);
      drain();
      issue({8'h01, 11'h7ff, 13'h0a0}, 1'b0, 1'b1);
      drain();

      // Bypass, back to back
      @(posedge clk);
      enable <= 1'b0;
      for (int i = 0; i < 20; i++) begin
         r = lcg_next();
         issue(r, r[0], r[1]);
      end
      drain();

      $display("Errors: %0d, checks: %0d, pending responses: %0d",
               errors, checks, exp_resp.size());
      if (errors == 0 && checks > 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+design
design/dmmu_tlb_pkg.sv
design/dmmu_spr_pkg.sv
design/tlb_ram.sv
design/dmmu_tlb_access.sv
design/dmmu_lookup.sv
design/dmmu_reload.sv
design/dmmu_top.sv
bench/page_table_mem.sv
bench/dmmu_tb.sv

// ==== Makefile ====
# Verilator build and run of the data MMU testbench

SRCS := $(wildcard design/*.sv design/*.svh bench/*.sv)

all: run

obj_dir/Vdmmu_tb: sim.f $(SRCS)
	verilator --binary --assert -f sim.f --top-module dmmu_tb -o Vdmmu_tb

run: obj_dir/Vdmmu_tb
	./obj_dir/Vdmmu_tb | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
